// ==== Bender.yml ====
package:
  name: lsp_expand

sources:
  # Design, package first
  - files:
      - src/lspExpandPkg.sv
      - src/lspFrameIn.sv
      - src/lspExpandPass.sv
      - src/lspFrameOut.sv
      - src/lspExpand.sv

  # Testbench with its included model
  - target: test
    include_dirs:
      - test
    files:
      - test/lspExpandTb.sv

// ==== lspExpand.f ====
+incdir+test
src/lspExpandPkg.sv
src/lspFrameIn.sv
src/lspExpandPass.sv
src/lspFrameOut.sv
src/lspExpand.sv
test/lspExpandTb.sv

// ==== src/lspExpand.sv ====
`timescale 1ns/1ps

module lspExpand import lspExpandPkg::*;
(
	input  logic                        clk,
	input  logic                        rstN,
	input  logic                        coefValid,
	input  logic signed [coefWidth-1:0] coefIn,
	input  logic        [gapWidth-1:0]  gap1,
	input  logic        [gapWidth-1:0]  gap2,
	output logic                        outValid,
	output logic signed [coefWidth-1:0] coefOut,
	output logic        [idxWidth-1:0]  coefIdx,
	output logic                        frameDone,
	output logic                        disordered
);

	// Framed input into the wide pass
	logic                        stgValid, stgFirst, stgLast;
	logic signed [coefWidth-1:0] stgData;
	logic        [coefWidth-1:0] gapNow, gapLater;

	// Between the two passes
	logic                        midValid, midFirst, midLast;
	logic signed [coefWidth-1:0] midData;
	logic        [coefWidth-1:0] midGap;

	// Into the output stage
	logic                        endValid, endFirst, endLast;
	logic signed [coefWidth-1:0] endData;

	////////////////////////////////////////////////////////////
	// Stage chain
	////////////////////////////////////////////////////////////

	lspFrameIn frameIn (
		.clk(clk), .rstN(rstN),
		.coefValid(coefValid), .coefIn(coefIn), .gap1(gap1), .gap2(gap2),
		.valid(stgValid), .first(stgFirst), .last(stgLast), .data(stgData),
		.gapNow(gapNow), .gapLater(gapLater)
	);

	// First pass uses gap1 and carries gap2 along to the second
	lspExpandPass passWide (
		.clk(clk), .rstN(rstN),
		.inValid(stgValid), .inFirst(stgFirst), .inLast(stgLast), .inData(stgData),
		.gap(gapNow), .laterGapIn(gapLater),
		.outValid(midValid), .outFirst(midFirst), .outLast(midLast), .outData(midData),
		.laterGapOut(midGap)
	);

	lspExpandPass passNarrow (
		.clk(clk), .rstN(rstN),
		.inValid(midValid), .inFirst(midFirst), .inLast(midLast), .inData(midData),
		.gap(midGap), .laterGapIn(midGap),
		.outValid(endValid), .outFirst(endFirst), .outLast(endLast), .outData(endData),
		.laterGapOut()
	);

	lspFrameOut frameOut (
		.clk(clk), .rstN(rstN),
		.inValid(endValid), .inFirst(endFirst), .inLast(endLast), .inData(endData),
		.coefValid(outValid), .coefOut(coefOut), .coefIdx(coefIdx),
		.frameDone(frameDone), .disordered(disordered)
	);

endmodule

// ==== src/lspExpandPass.sv ====
`timescale 1ns/1ps

module lspExpandPass import lspExpandPkg::*;
(
	input  logic                        clk,
	input  logic                        rstN,
	input  logic                        inValid,
	input  logic                        inFirst,
	input  logic                        inLast,
	input  logic signed [coefWidth-1:0] inData,
	input  logic        [coefWidth-1:0] gap,
	input  logic        [coefWidth-1:0] laterGapIn,
	output logic                        outValid,
	output logic                        outFirst,
	output logic                        outLast,
	output logic signed [coefWidth-1:0] outData,
	output logic        [coefWidth-1:0] laterGapOut
);

	// buf[j-1] while still open to adjustment by the next pair
	logic signed [coefWidth-1:0] pending;
	logic signed [coefWidth-1:0] gapHeld;
	logic        [coefWidth-1:0] laterGapHeld;

	// Next output is the first of its frame
	logic firstPending;
	// Last value still has to leave
	logic flushPending;

	logic signed [coefWidth-1:0] diff;
	logic signed [coefWidth-1:0] tmp;
	logic signed [coefWidth-1:0] finalPrev;
	logic signed [coefWidth-1:0] nextPending;

	////////////////////////////////////////////////////////////
	// Pairwise expansion of buf[j-1] and buf[j]
	////////////////////////////////////////////////////////////

	always_comb
	begin
		diff = satSub(pending, inData);
		tmp  = shrOne(satAdd(diff, gapHeld));
		// Pull the pair apart only when they are closer than the gap
		if (tmp > 0)
		begin
			finalPrev   = satSub(pending, tmp);
			nextPending = satAdd(inData, tmp);
		end
		else
		begin
			finalPrev   = pending;
			nextPending = inData;
		end
	end

	////////////////////////////////////////////////////////////
	// Output strobes and tags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			outValid     <= 1'b0;
			outFirst     <= 1'b0;
			outLast      <= 1'b0;
			firstPending <= 1'b0;
			flushPending <= 1'b0;
		end
		else
		begin
			outValid     <= 1'b0;
			outFirst     <= 1'b0;
			outLast      <= 1'b0;
			flushPending <= 1'b0;
			// Flush only ever meets an idle cycle or a first-tagged input
			if (flushPending)
			begin
				outValid <= 1'b1;
				outLast  <= 1'b1;
			end
			if (inValid && inFirst)
				firstPending <= 1'b1;
			if (inValid && !inFirst)
			begin
				outValid     <= 1'b1;
				outFirst     <= firstPending;
				firstPending <= 1'b0;
				flushPending <= inLast;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Data path registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (flushPending)
			outData <= pending;
		if (inValid)
		begin
			if (inFirst)
			begin
				pending      <= inData;
				gapHeld      <= gap;
				laterGapHeld <= laterGapIn;
			end
			else
			begin
				outData <= finalPrev;
				pending <= nextPending;
				// Next pass samples its gap with our first output
				if (firstPending)
					laterGapOut <= laterGapHeld;
			end
		end
	end

endmodule

// ==== src/lspExpandPkg.sv ====
package lspExpandPkg;

	////////////////////////////////////////////////////////////
	// Frame geometry and word widths
	////////////////////////////////////////////////////////////

	// One LSP coefficient, signed Q13
	localparam int coefWidth = 16;

	// Expansion gap, unsigned
	localparam int gapWidth = 4;

	// Coefficients per speech frame
	localparam int frameLen = 10;

	// Enough to index a whole frame
	localparam int idxWidth = 4;

	// Clamp limits of the signed coefficient range
	localparam logic signed [coefWidth-1:0] coefMax = {1'b0, {(coefWidth-1){1'b1}}};
	localparam logic signed [coefWidth-1:0] coefMin = {1'b1, {(coefWidth-1){1'b0}}};

	////////////////////////////////////////////////////////////
	// Saturating basic operators of the G.729 reference
	////////////////////////////////////////////////////////////

	// a + b clamped to the 16-bit signed range
	function automatic logic signed [coefWidth-1:0] satAdd(
		input logic signed [coefWidth-1:0] a,
		input logic signed [coefWidth-1:0] b
	);
		logic signed [coefWidth:0] sum;
		sum = a + b;
		// Top two bits disagree on overflow
		if (sum[coefWidth] != sum[coefWidth-1])
		begin
			if (sum[coefWidth])
				return coefMin;
			else
				return coefMax;
		end
		return sum[coefWidth-1:0];
	endfunction

	// a - b clamped to the 16-bit signed range
	function automatic logic signed [coefWidth-1:0] satSub(
		input logic signed [coefWidth-1:0] a,
		input logic signed [coefWidth-1:0] b
	);
		logic signed [coefWidth:0] diff;
		diff = a - b;
		if (diff[coefWidth] != diff[coefWidth-1])
		begin
			if (diff[coefWidth])
				return coefMin;
			else
				return coefMax;
		end
		return diff[coefWidth-1:0];
	endfunction

	// Halving keeps the sign and cannot overflow
	function automatic logic signed [coefWidth-1:0] shrOne(
		input logic signed [coefWidth-1:0] a
	);
		return a >>> 1;
	endfunction

endpackage

// ==== src/lspFrameIn.sv ====
`timescale 1ns/1ps

module lspFrameIn import lspExpandPkg::*;
(
	input  logic                        clk,
	input  logic                        rstN,
	input  logic                        coefValid,
	input  logic signed [coefWidth-1:0] coefIn,
	input  logic        [gapWidth-1:0]  gap1,
	input  logic        [gapWidth-1:0]  gap2,
	output logic                        valid,
	output logic                        first,
	output logic                        last,
	output logic signed [coefWidth-1:0] data,
	output logic        [coefWidth-1:0] gapNow,
	output logic        [coefWidth-1:0] gapLater
);

	// Position of the next accepted coefficient within its frame
	logic [idxWidth-1:0] coefCount;
	logic                atFirst;
	logic                atLast;

	assign atFirst = (coefCount == '0);
	assign atLast  = (coefCount == idxWidth'(frameLen - 1));

	////////////////////////////////////////////////////////////
	// Frame position and tags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			coefCount <= '0;
			valid     <= 1'b0;
			first     <= 1'b0;
			last      <= 1'b0;
		end
		else
		begin
			valid <= coefValid;
			if (coefValid)
			begin
				first <= atFirst;
				last  <= atLast;
				// Wrap after the tenth coefficient
				if (atLast)
					coefCount <= '0;
				else
					coefCount <= coefCount + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Coefficient and gap capture
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (coefValid)
		begin
			data <= coefIn;
			// Gaps are sampled once per frame and held until the next one
			if (atFirst)
			begin
				gapNow   <= {{(coefWidth-gapWidth){1'b0}}, gap1};
				gapLater <= {{(coefWidth-gapWidth){1'b0}}, gap2};
			end
		end
	end

endmodule

// ==== src/lspFrameOut.sv ====
`timescale 1ns/1ps

module lspFrameOut import lspExpandPkg::*;
(
	input  logic                        clk,
	input  logic                        rstN,
	input  logic                        inValid,
	input  logic                        inFirst,
	input  logic                        inLast,
	input  logic signed [coefWidth-1:0] inData,
	output logic                        coefValid,
	output logic signed [coefWidth-1:0] coefOut,
	output logic        [idxWidth-1:0]  coefIdx,
	output logic                        frameDone,
	output logic                        disordered
);

	// Frame has seen a pair that is not strictly increasing
	logic orderBad;
	logic stepBad;

	// coefOut still holds the previous coefficient of this frame
	assign stepBad = !inFirst && (inData <= coefOut);

	////////////////////////////////////////////////////////////
	// Numbering and ordering check
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			coefValid  <= 1'b0;
			coefIdx    <= '0;
			frameDone  <= 1'b0;
			disordered <= 1'b0;
			orderBad   <= 1'b0;
		end
		else
		begin
			coefValid <= inValid;
			frameDone <= 1'b0;
			if (inValid)
			begin
				if (inFirst)
					coefIdx <= '0;
				else
					coefIdx <= coefIdx + 1'b1;
				orderBad <= (orderBad && !inFirst) || stepBad;
				// Verdict is held until the next frame completes
				if (inLast)
				begin
					frameDone  <= 1'b1;
					disordered <= (orderBad && !inFirst) || stepBad;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (inValid)
			coefOut <= inData;
	end

endmodule

// ==== test/lspExpandModel.svh ====
`ifndef LSP_EXPAND_MODEL_SVH
`define LSP_EXPAND_MODEL_SVH

// Reference arithmetic on plain integers

localparam int modelLen = 10;
localparam int wordMax = 32767;
localparam int wordMin = -32768;

// One frame under expansion
int work [modelLen];

function automatic int clampWord(input int v);
	if (v > wordMax)
		return wordMax;
	if (v < wordMin)
		return wordMin;
	return v;
endfunction

function automatic int addClamped(input int a, input int b);
	return clampWord(a + b);
endfunction

function automatic int subClamped(input int a, input int b);
	return clampWord(a - b);
endfunction

// Halving rounds toward minus infinity
function automatic int halveFloor(input int a);
	if (a < 0)
		return -((1 - a) / 2);
	return a / 2;
endfunction

// One pass of the pairwise rule over work
function automatic void expandWork(input int gap);
	int diff;
	int tmp;
	for (int j = 1; j < modelLen; j++)
	begin
		diff = subClamped(work[j-1], work[j]);
		tmp  = halveFloor(addClamped(diff, gap));
		if (tmp > 0)
		begin
			work[j-1] = subClamped(work[j-1], tmp);
			work[j]   = addClamped(work[j], tmp);
		end
	end
endfunction

function automatic bit notIncreasing();
	bit bad;
	bad = 1'b0;
	for (int j = 1; j < modelLen; j++)
		if (work[j] <= work[j-1])
			bad = 1'b1;
	return bad;
endfunction

`endif

// ==== test/lspExpandTb.sv ====
`timescale 1ns/1ps

module lspExpandTb;

	`include "lspExpandModel.svh"

	// Frames over all tests set the run limit
	localparam int framesTotal = 74;
	localparam int cycleLimit = 20 * framesTotal * modelLen + 200;

	logic clk;
	logic rstN;
	logic coefValid;
	logic signed [15:0] coefIn;
	logic [3:0] gap1;
	logic [3:0] gap2;
	logic outValid;
	logic signed [15:0] coefOut;
	logic [3:0] coefIdx;
	logic frameDone;
	logic disordered;

	// Expected results in output order
	logic signed [15:0] expValue[$];
	int expIdx[$];
	bit expFlag[$];
	int tenthCycle[$];

	int stim [modelLen];
	int cycleCount = 0;
	bit [31:0] rngState = 32'd53;
	string currentTest;
	int testErrors;
	int passCount = 0;
	int failCount = 0;
	int ga;
	int gb;

	lspExpand dut (
		.clk(clk), .rstN(rstN),
		.coefValid(coefValid), .coefIn(coefIn), .gap1(gap1), .gap2(gap2),
		.outValid(outValid), .coefOut(coefOut), .coefIdx(coefIdx),
		.frameDone(frameDone), .disordered(disordered)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	initial
	begin
		while (cycleCount < cycleLimit)
			@(posedge clk);
		$display("Timeout after %0d cycles with %0d outputs still missing in %s",
			cycleCount, expValue.size(), currentTest);
		$display("TB FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic bit [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic int randBelow(input int n);
		return int'(nextRand() % n);
	endfunction

	task automatic fillAscending();
		int v;
		v = -20000 + randBelow(2000);
		for (int i = 0; i < modelLen; i++)
		begin
			stim[i] = v;
			v = v + 1 + randBelow(4000);
		end
	endtask

	// Steps of -8..15 give equal and reversed pairs
	task automatic fillCrowded();
		int v;
		v = randBelow(6000) - 3000;
		for (int i = 0; i < modelLen; i++)
		begin
			stim[i] = v;
			v = v + randBelow(24) - 8;
		end
	endtask

	task automatic fillSaturated();
		for (int i = 0; i < modelLen; i++)
			if (randBelow(2) == 1)
				stim[i] = wordMax - randBelow(8);
			else
				stim[i] = wordMin + randBelow(8);
	endtask

	task automatic sendFrame(input int gapA, input int gapB, input int maxIdle);
		bit flag;
		int idle;
		for (int i = 0; i < modelLen; i++)
			work[i] = stim[i];
		expandWork(gapA);
		expandWork(gapB);
		flag = notIncreasing();
		for (int i = 0; i < modelLen; i++)
		begin
			expValue.push_back(16'(work[i]));
			expIdx.push_back(i);
		end
		expFlag.push_back(flag);
		for (int i = 0; i < modelLen; i++)
		begin
			idle = (maxIdle > 0) ? randBelow(maxIdle + 1) : 0;
			repeat (idle)
			begin
				@(posedge clk);
				#1;
				coefValid = 1'b0;
			end
			@(posedge clk);
			#1;
			coefValid = 1'b1;
			coefIn = 16'(stim[i]);
			// Junk gaps away from the first coefficient
			if (i == 0)
			begin
				gap1 = 4'(gapA);
				gap2 = 4'(gapB);
			end
			else
			begin
				gap1 = 4'(nextRand());
				gap2 = 4'(nextRand());
			end
			if (i == modelLen - 1)
				tenthCycle.push_back(cycleCount);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Checking and bookkeeping
	////////////////////////////////////////////////////////////

	task automatic logFailure(input string msg);
		$display("%s", msg);
		testErrors = testErrors + 1;
	endtask

	task automatic startTest(input string name);
		currentTest = name;
		testErrors = 0;
	endtask

	task automatic finishTest();
		@(posedge clk);
		#1;
		coefValid = 1'b0;
		while (expValue.size() != 0)
			@(posedge clk);
		// Room for any extra output to show up
		repeat (8) @(posedge clk);
		$display("%s: %0d errors", currentTest, testErrors);
		if (testErrors == 0)
			passCount = passCount + 1;
		else
			failCount = failCount + 1;
	endtask

	task automatic checkQuiet(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			if (outValid || frameDone || disordered)
				logFailure("Outputs went active before any coefficient was sent");
		end
	endtask

	always @(negedge clk)
	begin : watchOutputs
		logic signed [15:0] ev;
		int ei;
		bit ef;
		int et;
		if (rstN && outValid)
		begin
			if (expValue.size() == 0)
				logFailure($sformatf("Output %0d in %s arrived with nothing expected",
					coefOut, currentTest));
			else
			begin
				ev = expValue.pop_front();
				ei = expIdx.pop_front();
				if (coefOut !== ev)
					logFailure($sformatf("Mismatch %s coefOut[%0d]: expected %0d, actual %0d",
						currentTest, ei, ev, coefOut));
				if (coefIdx !== 4'(ei))
					logFailure($sformatf("Mismatch %s coefIdx: expected %0d, actual %0d",
						currentTest, ei, coefIdx));
				if (frameDone !== (ei == modelLen - 1))
					logFailure($sformatf("Mismatch %s frameDone[%0d]: expected %0b, actual %b",
						currentTest, ei, (ei == modelLen - 1), frameDone));
				if (ei == modelLen - 1)
				begin
					ef = expFlag.pop_front();
					et = tenthCycle.pop_front();
					if (disordered !== ef)
						logFailure($sformatf("Mismatch %s disordered: expected %0b, actual %0b",
							currentTest, ef, disordered));
					if (cycleCount - et != 6)
						logFailure($sformatf("Mismatch %s frame end delay: expected 6, actual %0d",
							currentTest, cycleCount - et));
				end
			end
		end
		else if (rstN && frameDone)
			logFailure($sformatf("frameDone pulsed without an output in %s", currentTest));
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		rstN = 1'b0;
		coefValid = 1'b0;
		coefIn = '0;
		gap1 = '0;
		gap2 = '0;
		repeat (8) @(posedge clk);
		#1;
		rstN = 1'b1;

		startTest("frame timing");
		checkQuiet(20);
		for (int f = 0; f < 4; f++)
		begin
			fillAscending();
			ga = randBelow(16);
			gb = randBelow(16);
			sendFrame(ga, gb, (f < 2) ? 0 : 4);
		end
		finishTest();

		startTest("random frames");
		for (int f = 0; f < 20; f++)
		begin
			fillAscending();
			ga = randBelow(16);
			gb = randBelow(16);
			sendFrame(ga, gb, 0);
		end
		finishTest();

		startTest("crowded frames");
		for (int f = 0; f < 20; f++)
		begin
			fillCrowded();
			ga = 8 + randBelow(8);
			gb = 8 + randBelow(8);
			sendFrame(ga, gb, 0);
		end
		finishTest();

		startTest("saturation");
		for (int f = 0; f < 10; f++)
		begin
			fillSaturated();
			sendFrame(15, 15, 0);
		end
		finishTest();

		// Same frame back to back and then spread out
		startTest("idle cycles");
		for (int f = 0; f < 10; f++)
		begin
			fillCrowded();
			ga = randBelow(16);
			gb = randBelow(16);
			sendFrame(ga, gb, 0);
			sendFrame(ga, gb, 3);
		end
		finishTest();

		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
